// ==== files.f ====
hw/video_types_pkg.sv
hw/xr_regs_pkg.sv
hw/video_beat_if.sv
hw/pf_config_if.sv
hw/video_timing.sv
hw/xr_registers.sv
hw/pf_fetch.sv
hw/pf_pixel.sv
hw/video_gen.sv
tb/video_gen_assertions.sv
tb/video_gen_tb.sv

// ==== hw/pf_config_if.sv ====
// border and playfield settings, driven by the register block and read by the fetch and pixel stages
`default_nettype none
`timescale 1ns/100ps

interface pf_config_if;

video_types_pkg::color_t    border_color;
video_types_pkg::hpos_t     vid_left;       // first pixel inside the window
video_types_pkg::hpos_t     vid_right;      // first pixel past the window
logic                       pa_blank;       // playfield off, border only
video_types_pkg::color_t    pa_colorbase;   // XOR'd into every playfield pixel
video_types_pkg::addr_t     pa_start_addr;  // loaded at end of frame
video_types_pkg::word_t     pa_line_len;    // words added per visible line

modport regs (output border_color, vid_left, vid_right, pa_blank, pa_colorbase,
              pa_start_addr, pa_line_len);
modport stage (input border_color, vid_left, vid_right, pa_blank, pa_colorbase,
               pa_start_addr, pa_line_len);

endinterface

`default_nettype wire

// ==== hw/pf_fetch.sv ====
// fetch stage: tracks the playfield line address and issues video RAM reads, one cycle behind timing
`default_nettype none
`timescale 1ns/100ps

module pf_fetch (
    input  wire logic               clk,
    input  wire logic               reset_i,
    video_beat_if.fetch_stage       beat_i,
    video_beat_if.source            beat_o,
    pf_config_if.stage              cfg_i,
    output logic                    vram_sel_o,
    output video_types_pkg::addr_t  vram_addr_o
);

video_types_pkg::addr_t line_addr;  // first word of the current line

always_ff @(posedge clk) begin
    if (reset_i) begin
        line_addr <= '0;
    end else if (beat_i.end_of_frame) begin
        line_addr <= cfg_i.pa_start_addr;               // rewind for the next frame
    end else if (beat_i.end_of_line && beat_i.v_visible) begin
        line_addr <= line_addr + cfg_i.pa_line_len;
    end
end

// one word holds two pixels, so read on even x only
always_ff @(posedge clk) begin
    if (reset_i) begin
        vram_sel_o <= 1'b0;
    end else begin
        vram_sel_o <= beat_i.h_visible && beat_i.v_visible && !beat_i.h_count[0] &&
                      !cfg_i.pa_blank;
    end
    vram_addr_o <= line_addr + video_types_pkg::addr_t'(beat_i.h_count >> 1);
end

// beat delayed to line up with vram_sel_o
always_ff @(posedge clk) begin
    beat_o.h_count        <= beat_i.h_count;
    beat_o.v_count        <= beat_i.v_count;
    beat_o.h_visible      <= beat_i.h_visible;
    beat_o.v_visible      <= beat_i.v_visible;
    beat_o.hsync          <= beat_i.hsync;
    beat_o.vsync          <= beat_i.vsync;
    beat_o.end_of_line    <= beat_i.end_of_line;
    beat_o.end_of_frame   <= beat_i.end_of_frame;
    beat_o.end_of_visible <= beat_i.end_of_visible;
end

endmodule

`default_nettype wire

// ==== hw/pf_pixel.sv ====
// pixel stage: picks bytes from the fetched words, applies color base and border, registers outputs
`default_nettype none
`timescale 1ns/100ps

module pf_pixel (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    video_beat_if.sink                  beat_i,
    pf_config_if.stage                  cfg_i,
    input  wire video_types_pkg::word_t vram_data_i,
    output video_types_pkg::color_t     color_index_o,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        h_blank_o,
    output logic                        v_blank_o,
    output logic                        dv_de_o
);

video_types_pkg::hpos_t     d_h_count;      // beat_f one cycle later, meets the RAM data
logic                       d_h_visible;
logic                       d_v_visible;
logic                       d_hsync;
logic                       d_vsync;
video_types_pkg::color_t    pix_lo;         // low byte kept for the odd pixel
video_types_pkg::color_t    pix_byte;
logic                       show_pf;        // inside window and not blanked

always_ff @(posedge clk) begin
    d_h_count   <= beat_i.h_count;
    d_h_visible <= beat_i.h_visible;
    d_v_visible <= beat_i.v_visible;
    d_hsync     <= beat_i.hsync;
    d_vsync     <= beat_i.vsync;
    if (!d_h_count[0]) begin
        pix_lo <= vram_data_i[7:0];
    end
end

always_comb begin
    pix_byte = d_h_count[0] ? pix_lo : vram_data_i[15:8];  // high byte first
    show_pf  = (d_h_count >= cfg_i.vid_left) && (d_h_count < cfg_i.vid_right) && !cfg_i.pa_blank;
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        color_index_o <= '0;
        hsync_o       <= 1'b0;
        vsync_o       <= 1'b0;
        h_blank_o     <= 1'b1;
        v_blank_o     <= 1'b1;
        dv_de_o       <= 1'b0;
    end else begin
        hsync_o   <= d_hsync;
        vsync_o   <= d_vsync;
        h_blank_o <= !d_h_visible;
        v_blank_o <= !d_v_visible;
        dv_de_o   <= d_h_visible && d_v_visible;
        if (!(d_h_visible && d_v_visible)) begin
            color_index_o <= '0;                            // black outside the raster
        end else if (show_pf) begin
            color_index_o <= pix_byte ^ cfg_i.pa_colorbase;
        end else begin
            color_index_o <= cfg_i.border_color;
        end
    end
end

endmodule

`default_nettype wire

// ==== hw/video_beat_if.sv ====
// one pixel position with its sync and frame flags, handed from one pipeline stage to the next
`default_nettype none
`timescale 1ns/100ps

interface video_beat_if;

video_types_pkg::hpos_t h_count;    // pixel within line
video_types_pkg::vpos_t v_count;    // line within frame
logic   h_visible;
logic   v_visible;
logic   hsync;                      // active high
logic   vsync;                      // active high
logic   end_of_line;                // last pixel of every line
logic   end_of_frame;               // last pixel of the frame
logic   end_of_visible;             // last visible pixel of the frame

modport source (output h_count, v_count, h_visible, v_visible, hsync, vsync,
                end_of_line, end_of_frame, end_of_visible);
modport fetch_stage (input h_count, v_count, h_visible, v_visible, hsync, vsync,
                     end_of_line, end_of_frame, end_of_visible);
modport sink (input h_count, v_count, h_visible, v_visible, hsync, vsync,
              end_of_line, end_of_frame, end_of_visible);

endinterface

`default_nettype wire

// ==== hw/video_gen.sv ====
// video generator top level: joins timing, fetch, pixel and register blocks to plain ports
`default_nettype none
`timescale 1ns/100ps

module video_gen #(
    parameter int H_VISIBLE = 16,
    parameter int H_FRONT   = 2,
    parameter int H_SYNC    = 3,
    parameter int H_BACK    = 3,
    parameter int V_VISIBLE = 8,
    parameter int V_FRONT   = 1,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 1
) (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       reg_wr_i,       // register write strobe
    input  wire video_types_pkg::reg_num_t  reg_num_i,
    input  wire video_types_pkg::word_t     reg_data_i,
    output video_types_pkg::word_t          reg_data_o,     // readback, one cycle late
    output video_types_pkg::intr_t          intr_o,
    output logic                            vram_sel_o,
    output video_types_pkg::addr_t          vram_addr_o,
    input  wire video_types_pkg::word_t     vram_data_i,    // valid the cycle after vram_sel_o
    output video_types_pkg::color_t         color_index_o,
    output logic                            hsync_o,
    output logic                            vsync_o,
    output logic                            h_blank_o,
    output logic                            v_blank_o,
    output logic                            dv_de_o
);

video_beat_if beat_t();     // from timing
video_beat_if beat_f();     // one cycle later, from fetch
pf_config_if  cfg();

video_timing #(
    .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
) timing_i (
    .clk(clk),
    .reset_i(reset_i),
    .beat_o(beat_t)
);

xr_registers #(
    .H_VISIBLE(H_VISIBLE),
    .V_VISIBLE(V_VISIBLE)
) regs_i (
    .clk(clk),
    .reset_i(reset_i),
    .reg_wr_i(reg_wr_i),
    .reg_num_i(reg_num_i),
    .reg_data_i(reg_data_i),
    .reg_data_o(reg_data_o),
    .intr_o(intr_o),
    .beat_i(beat_t),
    .cfg_o(cfg)
);

pf_fetch fetch_i (
    .clk(clk),
    .reset_i(reset_i),
    .beat_i(beat_t),
    .beat_o(beat_f),
    .cfg_i(cfg),
    .vram_sel_o(vram_sel_o),
    .vram_addr_o(vram_addr_o)
);

pf_pixel pixel_i (
    .clk(clk),
    .reset_i(reset_i),
    .beat_i(beat_f),
    .cfg_i(cfg),
    .vram_data_i(vram_data_i),
    .color_index_o(color_index_o),
    .hsync_o(hsync_o),
    .vsync_o(vsync_o),
    .h_blank_o(h_blank_o),
    .v_blank_o(v_blank_o),
    .dv_de_o(dv_de_o)
);

endmodule

`default_nettype wire

// ==== hw/video_timing.sv ====
// raster timing stage: pixel and line counters, syncs, visible flags and frame events
`default_nettype none
`timescale 1ns/100ps

module video_timing #(
    parameter int H_VISIBLE = 16,
    parameter int H_FRONT   = 2,
    parameter int H_SYNC    = 3,
    parameter int H_BACK    = 3,
    parameter int V_VISIBLE = 8,
    parameter int V_FRONT   = 1,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 1
) (
    input  wire logic       clk,
    input  wire logic       reset_i,
    video_beat_if.source    beat_o
);

localparam video_types_pkg::hpos_t H_VIS      = video_types_pkg::hpos_t'(H_VISIBLE);
localparam video_types_pkg::hpos_t H_SYNC_ON  = video_types_pkg::hpos_t'(H_VISIBLE + H_FRONT);
localparam video_types_pkg::hpos_t H_SYNC_OFF = H_SYNC_ON + video_types_pkg::hpos_t'(H_SYNC);
localparam video_types_pkg::hpos_t H_LAST     = H_SYNC_OFF + video_types_pkg::hpos_t'(H_BACK - 1);
localparam video_types_pkg::vpos_t V_VIS      = video_types_pkg::vpos_t'(V_VISIBLE);
localparam video_types_pkg::vpos_t V_SYNC_ON  = video_types_pkg::vpos_t'(V_VISIBLE + V_FRONT);
localparam video_types_pkg::vpos_t V_SYNC_OFF = V_SYNC_ON + video_types_pkg::vpos_t'(V_SYNC);
localparam video_types_pkg::vpos_t V_LAST     = V_SYNC_OFF + video_types_pkg::vpos_t'(V_BACK - 1);

video_types_pkg::hpos_t h_cnt;
video_types_pkg::vpos_t v_cnt;
logic                   last_pixel;     // last pixel of the line
logic                   last_line;      // last line of the frame

always_comb last_pixel = (h_cnt == H_LAST);
always_comb last_line  = (v_cnt == V_LAST);

// free running raster counters
always_ff @(posedge clk) begin
    if (reset_i) begin
        h_cnt <= '0;
        v_cnt <= '0;
    end else if (last_pixel) begin
        h_cnt <= '0;
        v_cnt <= last_line ? '0 : v_cnt + 1'b1;
    end else begin
        h_cnt <= h_cnt + 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        beat_o.h_count        <= '0;
        beat_o.v_count        <= '0;
        beat_o.h_visible      <= 1'b0;
        beat_o.v_visible      <= 1'b0;
        beat_o.hsync          <= 1'b0;
        beat_o.vsync          <= 1'b0;
        beat_o.end_of_line    <= 1'b0;
        beat_o.end_of_frame   <= 1'b0;
        beat_o.end_of_visible <= 1'b0;
    end else begin
        beat_o.h_count        <= h_cnt;
        beat_o.v_count        <= v_cnt;
        beat_o.h_visible      <= (h_cnt < H_VIS);
        beat_o.v_visible      <= (v_cnt < V_VIS);
        beat_o.hsync          <= (h_cnt >= H_SYNC_ON) && (h_cnt < H_SYNC_OFF);    // after front porch
        beat_o.vsync          <= (v_cnt >= V_SYNC_ON) && (v_cnt < V_SYNC_OFF);
        beat_o.end_of_line    <= last_pixel;
        beat_o.end_of_frame   <= last_pixel && last_line;
        beat_o.end_of_visible <= (h_cnt == H_VIS - 1'b1) && (v_cnt == V_VIS - 1'b1);
    end
end

endmodule

`default_nettype wire

// ==== hw/video_types_pkg.sv ====
// vector types shared by all video stages, referenced by scoped name (video_types_pkg::word_t)
`default_nettype none

package video_types_pkg;

typedef logic [15:0] word_t;        // register or video RAM data word
typedef logic [15:0] addr_t;        // video RAM word address
typedef logic [7:0]  color_t;       // palette index
typedef logic [9:0]  hpos_t;        // pixel count within a line
typedef logic [9:0]  vpos_t;        // line count within a frame
typedef logic [5:0]  reg_num_t;     // control register number
typedef logic [3:0]  intr_t;        // interrupt vector, one bit per source

endpackage

`default_nettype wire

// ==== hw/xr_registers.sv ====
// control register block: write decode, one-cycle readback and interrupt pulses
`default_nettype none
`timescale 1ns/100ps

module xr_registers #(
    parameter int H_VISIBLE = 16,
    parameter int V_VISIBLE = 8
) (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       reg_wr_i,
    input  wire video_types_pkg::reg_num_t  reg_num_i,
    input  wire video_types_pkg::word_t     reg_data_i,
    output video_types_pkg::word_t          reg_data_o,
    output video_types_pkg::intr_t          intr_o,
    video_beat_if.sink                      beat_i,
    pf_config_if.regs                       cfg_o
);

video_types_pkg::word_t rd_data;    // value of the register addressed this cycle

always_ff @(posedge clk) begin
    if (reset_i) begin
        intr_o              <= '0;
        cfg_o.border_color  <= xr_regs_pkg::BORDER_RESET;
        cfg_o.vid_left      <= '0;
        cfg_o.vid_right     <= video_types_pkg::hpos_t'(H_VISIBLE);
        cfg_o.pa_blank      <= 1'b1;
        cfg_o.pa_colorbase  <= '0;
        cfg_o.pa_start_addr <= '0;
        cfg_o.pa_line_len   <= video_types_pkg::word_t'(H_VISIBLE / 2);    // two pixels per word
    end else begin
        intr_o <= '0;                                       // pulses last one cycle
        if (reg_wr_i) begin
            case (reg_num_i)
                xr_regs_pkg::XR_VID_CTRL: begin
                    cfg_o.border_color <= reg_data_i[15:8];
                    intr_o             <= reg_data_i[3:0];  // software interrupts
                end
                xr_regs_pkg::XR_VID_LEFT: begin
                    cfg_o.vid_left <= video_types_pkg::hpos_t'(reg_data_i);
                end
                xr_regs_pkg::XR_VID_RIGHT: begin
                    cfg_o.vid_right <= video_types_pkg::hpos_t'(reg_data_i);
                end
                xr_regs_pkg::XR_PA_GFX_CTRL: begin
                    cfg_o.pa_colorbase <= reg_data_i[15:8];
                    cfg_o.pa_blank     <= reg_data_i[xr_regs_pkg::PA_BLANK_BIT];
                end
                xr_regs_pkg::XR_PA_DISP_ADDR: begin
                    cfg_o.pa_start_addr <= reg_data_i;
                end
                xr_regs_pkg::XR_PA_LINE_LEN: begin
                    cfg_o.pa_line_len <= reg_data_i;
                end
                default: begin
                end
            endcase
        end
        if (beat_i.end_of_visible) begin
            intr_o[xr_regs_pkg::VSYNC_INTR] <= 1'b1;        // frame done, vblank starts
        end
    end
end

// readback mux
always_comb begin
    rd_data = '0;
    case (reg_num_i)
        xr_regs_pkg::XR_VID_CTRL:     rd_data[15:8] = cfg_o.border_color;
        xr_regs_pkg::XR_VID_LEFT:     rd_data = video_types_pkg::word_t'(cfg_o.vid_left);
        xr_regs_pkg::XR_VID_RIGHT:    rd_data = video_types_pkg::word_t'(cfg_o.vid_right);
        xr_regs_pkg::XR_SCANLINE:     rd_data = video_types_pkg::word_t'(beat_i.v_count);
        xr_regs_pkg::XR_VID_HSIZE:    rd_data = video_types_pkg::word_t'(H_VISIBLE);
        xr_regs_pkg::XR_VID_VSIZE:    rd_data = video_types_pkg::word_t'(V_VISIBLE);
        xr_regs_pkg::XR_PA_GFX_CTRL: begin
            rd_data[15:8]                     = cfg_o.pa_colorbase;
            rd_data[xr_regs_pkg::PA_BLANK_BIT] = cfg_o.pa_blank;
        end
        xr_regs_pkg::XR_PA_DISP_ADDR: rd_data = cfg_o.pa_start_addr;
        xr_regs_pkg::XR_PA_LINE_LEN:  rd_data = cfg_o.pa_line_len;
        default: begin
        end
    endcase
end

always_ff @(posedge clk) begin
    reg_data_o <= rd_data;                                  // read data one cycle after address
end

endmodule

`default_nettype wire

// ==== hw/xr_regs_pkg.sv ====
// control register map of the video generator, used by the register block and the testbench
`default_nettype none

package xr_regs_pkg;

// video control registers
localparam video_types_pkg::reg_num_t XR_VID_CTRL     = 6'd0;     // border color, intr bits
localparam video_types_pkg::reg_num_t XR_VID_LEFT     = 6'd4;     // left window edge
localparam video_types_pkg::reg_num_t XR_VID_RIGHT    = 6'd5;     // right window edge
localparam video_types_pkg::reg_num_t XR_SCANLINE     = 6'd8;     // read only
localparam video_types_pkg::reg_num_t XR_VID_HSIZE    = 6'd10;    // read only
localparam video_types_pkg::reg_num_t XR_VID_VSIZE    = 6'd11;    // read only

// playfield registers
localparam video_types_pkg::reg_num_t XR_PA_GFX_CTRL  = 6'd16;    // color base, blank
localparam video_types_pkg::reg_num_t XR_PA_DISP_ADDR = 6'd18;    // frame start word address
localparam video_types_pkg::reg_num_t XR_PA_LINE_LEN  = 6'd19;    // words per line

// field positions
localparam int VSYNC_INTR   = 3;    // end of visible frame interrupt bit
localparam int PA_BLANK_BIT = 7;    // blank bit in XR_PA_GFX_CTRL

// reset values
localparam video_types_pkg::color_t BORDER_RESET = 8'h08;    // dark grey, shows the chip is alive

endpackage

`default_nettype wire

// ==== tb/video_gen_assertions.sv ====
// concurrent checks on the video generator outputs, bound into video_gen by the bind at the end
`default_nettype none
`timescale 1ns/100ps

module video_gen_assertions (
    input wire logic                    clk,
    input wire logic                    reset_i,
    input wire logic                    vram_sel_o,
    input wire logic                    dv_de_o,
    input wire logic                    hsync_o,
    input wire logic                    vsync_o,
    input wire video_types_pkg::intr_t  intr_o
);

int failures = 0;   // assertion failures so far

sel_single_cycle: assert property (@(posedge clk) disable iff (reset_i)
    vram_sel_o |=> !vram_sel_o)
    else begin
        failures++;
        $error("vram_sel_o was high on two consecutive cycles");
    end

de_outside_sync: assert property (@(posedge clk) disable iff (reset_i)
    !(dv_de_o && (hsync_o || vsync_o)))
    else begin
        failures++;
        $error("dv_de_o was high during hsync_o or vsync_o");
    end

intr_single_cycle: assert property (@(posedge clk) disable iff (reset_i)
    (intr_o & $past(intr_o)) == '0)
    else begin
        failures++;
        $error("an intr_o bit stayed high for more than one cycle");
    end

sel_low_in_reset: assert property (@(posedge clk)
    reset_i && $past(reset_i) |-> !vram_sel_o)
    else begin
        failures++;
        $error("vram_sel_o was high while reset_i was held");
    end

endmodule

bind video_gen video_gen_assertions checks_i (
    .clk(clk),
    .reset_i(reset_i),
    .vram_sel_o(vram_sel_o),
    .dv_de_o(dv_de_o),
    .hsync_o(hsync_o),
    .vsync_o(vsync_o),
    .intr_o(intr_o)
);

`default_nettype wire

// ==== tb/video_gen_tb.sv ====
// testbench for video_gen: models the video RAM, programs registers and checks every visible pixel
`default_nettype none
`timescale 1ns/100ps

module video_gen_tb;

localparam int H_VISIBLE = 16;
localparam int H_FRONT = 2;
localparam int H_SYNC = 3;
localparam int H_BACK = 3;
localparam int V_VISIBLE = 8;
localparam int V_FRONT = 1;
localparam int V_SYNC = 2;
localparam int V_BACK = 1;
localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
localparam int TIMEOUT_CYCLES = 12 * H_TOTAL * V_TOTAL + 544;  // twelve frames plus reg traffic
localparam logic [31:0] SEED = 32'hcedd;
localparam video_types_pkg::intr_t SW_MASK = ~(4'b0001 << xr_regs_pkg::VSYNC_INTR);

logic clk;
logic reset_i;
logic reg_wr_i;
video_types_pkg::reg_num_t reg_num_i;
video_types_pkg::word_t reg_data_i;
video_types_pkg::word_t reg_data_o;
video_types_pkg::intr_t intr_o;
logic vram_sel_o;
video_types_pkg::addr_t vram_addr_o;
video_types_pkg::word_t vram_data_i;
video_types_pkg::color_t color_index_o;
logic hsync_o;
logic vsync_o;
logic h_blank_o;
logic v_blank_o;
logic dv_de_o;

// register values as programmed, the basis of the expected pixels
video_types_pkg::color_t m_border;
int m_left;
int m_right;
logic m_blank;
video_types_pkg::color_t m_colorbase;
video_types_pkg::addr_t m_start;
video_types_pkg::word_t m_line_len;

int pixel_errors = 0;
int frame_errors = 0;
int sync_errors = 0;
int reg_errors = 0;
int intr_errors = 0;
int cycle_count = 0;
int frames = 0;
int sw_intr_count = 0;
int de_count;
int vs_intr_count;
int px;
int py;
int hx;             // raster position of the outputs
int vy;
logic raster_known; // set once the first vsync edge fixes hx and vy
logic vsync_d;
logic frame_seen;
logic check_en;

video_gen dut_i (.*);

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

function automatic video_types_pkg::word_t ram_word(input video_types_pkg::addr_t addr);
    logic [31:0] h;
    h = xorshift32(xorshift32(SEED ^ {addr, addr}));
    return h[15:0];
endfunction

// expected palette index of visible pixel x, y
function automatic video_types_pkg::color_t expected_pixel(input int x, input int y);
    video_types_pkg::addr_t addr;
    video_types_pkg::word_t w;
    if (m_blank || x < m_left || x >= m_right) begin
        return m_border;
    end else begin
        addr = m_start + video_types_pkg::addr_t'(y) * m_line_len +
               video_types_pkg::addr_t'(x / 2);
        w = ram_word(addr);
        return ((x % 2 == 0) ? w[15:8] : w[7:0]) ^ m_colorbase;  // high byte first
    end
endfunction

// expected {hsync, vsync, h_blank, v_blank, de} at raster position x, y
function automatic logic [4:0] expected_sync(input int x, input int y);
    logic hb;
    logic vb;
    hb = x >= H_VISIBLE;
    vb = y >= V_VISIBLE;
    return {(x >= H_VISIBLE + H_FRONT) && (x < H_VISIBLE + H_FRONT + H_SYNC),
            (y >= V_VISIBLE + V_FRONT) && (y < V_VISIBLE + V_FRONT + V_SYNC),
            hb, vb, !hb && !vb};
endfunction

always #20 clk = ~clk;

always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end
end

always @(posedge clk) begin
    if (vram_sel_o) begin
        vram_data_i <= ram_word(vram_addr_o);      // one cycle read latency
    end
end

// pixel, sync, frame and interrupt comparison
always @(posedge clk) begin
    video_types_pkg::color_t expected;
    logic [4:0] exp_sync;
    if (reset_i) begin
        px <= 0;
        py <= 0;
        hx <= 0;
        vy <= 0;
        raster_known <= 1'b0;
        de_count <= 0;
        vs_intr_count <= 0;
        frame_seen <= 1'b0;
        vsync_d <= 1'b0;
    end else begin
        if (dv_de_o) begin
            if (check_en) begin
                expected = expected_pixel(px, py);
                if (color_index_o !== expected) begin
                    pixel_errors <= pixel_errors + 1;
                    $display("Error: color_index_o at x %0d y %0d is %h, expected %h",
                             px, py, color_index_o, expected);
                end
            end
            px <= px + 1;
            de_count <= de_count + 1;
        end else if (px != 0) begin
            px <= 0;                                // line done
            py <= py + 1;
        end
        if (raster_known) begin
            exp_sync = expected_sync(hx, vy);
            if ({hsync_o, vsync_o, h_blank_o, v_blank_o, dv_de_o} !== exp_sync) begin
                sync_errors <= sync_errors + 1;
                $display("Error: hsync_o vsync_o h_blank_o v_blank_o dv_de_o are %h, expected %h",
                         {hsync_o, vsync_o, h_blank_o, v_blank_o, dv_de_o}, exp_sync);
            end
        end
        if (!raster_known && vsync_o && !vsync_d) begin
            raster_known <= 1'b1;                   // vsync starts at x 0 of its first line
            hx <= 1;
            vy <= V_VISIBLE + V_FRONT;
        end else if (hx == H_TOTAL - 1) begin
            hx <= 0;
            vy <= (vy == V_TOTAL - 1) ? 0 : vy + 1;
        end else begin
            hx <= hx + 1;
        end
        if (intr_o[xr_regs_pkg::VSYNC_INTR]) begin
            vs_intr_count <= vs_intr_count + 1;
        end
        if ((intr_o & SW_MASK) != '0) begin
            sw_intr_count <= sw_intr_count + 1;
        end
        vsync_d <= vsync_o;
        if (vsync_o && !vsync_d) begin
            if (frame_seen && de_count != H_VISIBLE * V_VISIBLE) begin
                frame_errors <= frame_errors + 1;
                $display("Error: dv_de_o count per frame is %h, expected %h",
                         de_count, H_VISIBLE * V_VISIBLE);
            end
            if (frame_seen && vs_intr_count != 1) begin
                frame_errors <= frame_errors + 1;
                $display("The vsync interrupt pulsed %0d times in one frame", vs_intr_count);
            end
            py <= 0;
            de_count <= 0;
            vs_intr_count <= 0;
            frame_seen <= 1'b1;
            frames <= frames + 1;
        end
    end
end

task automatic write_reg(input video_types_pkg::reg_num_t num, input video_types_pkg::word_t data);
    @(posedge clk);
    reg_wr_i <= 1'b1;
    reg_num_i <= num;
    reg_data_i <= data;
    @(posedge clk);
    reg_wr_i <= 1'b0;
    case (num)
        xr_regs_pkg::XR_VID_CTRL:     m_border = data[15:8];
        xr_regs_pkg::XR_VID_LEFT:     m_left = int'(data[9:0]);
        xr_regs_pkg::XR_VID_RIGHT:    m_right = int'(data[9:0]);
        xr_regs_pkg::XR_PA_GFX_CTRL: begin
            m_colorbase = data[15:8];
            m_blank = data[7];
        end
        xr_regs_pkg::XR_PA_DISP_ADDR: m_start = data;
        xr_regs_pkg::XR_PA_LINE_LEN:  m_line_len = data;
        default: begin
        end
    endcase
endtask

task automatic read_reg(input video_types_pkg::reg_num_t num, output video_types_pkg::word_t data);
    @(posedge clk);
    reg_num_i <= num;
    @(posedge clk);                                 // readback registered here
    @(posedge clk);
    data = reg_data_o;
endtask

task automatic check_reg(input video_types_pkg::reg_num_t num, input video_types_pkg::word_t exp);
    video_types_pkg::word_t data;
    read_reg(num, data);
    if (data !== exp) begin
        reg_errors++;
        $display("Error: reg_data_o of register %h is %h, expected %h", num, data, exp);
    end
endtask

task automatic write_check(input video_types_pkg::reg_num_t num,
                           input video_types_pkg::word_t data,
                           input video_types_pkg::word_t exp);
    write_reg(num, data);
    check_reg(num, exp);
endtask

// skip to the next frame start, then compare n whole frames
task automatic check_frames(input int n);
    int target;
    target = frames + 1;
    while (frames < target) @(posedge clk);
    check_en <= 1'b1;
    target = target + n;
    while (frames < target) @(posedge clk);
    check_en <= 1'b0;
endtask

initial begin
    video_types_pkg::word_t data;
    int total;
    clk = 1'b0;
    reset_i = 1'b1;
    reg_wr_i = 1'b0;
    reg_num_i = '0;
    reg_data_i = '0;
    vram_data_i = '0;
    check_en = 1'b0;
    m_border = xr_regs_pkg::BORDER_RESET;
    m_left = 0;
    m_right = H_VISIBLE;
    m_blank = 1'b1;
    m_colorbase = '0;
    m_start = '0;
    m_line_len = H_VISIBLE / 2;
    repeat (10) @(posedge clk);
    reset_i <= 1'b0;

    check_reg(xr_regs_pkg::XR_VID_CTRL, {xr_regs_pkg::BORDER_RESET, 8'h00});
    check_reg(xr_regs_pkg::XR_VID_RIGHT, H_VISIBLE);
    check_reg(xr_regs_pkg::XR_PA_LINE_LEN, H_VISIBLE / 2);
    check_reg(xr_regs_pkg::XR_VID_HSIZE, H_VISIBLE);
    check_reg(xr_regs_pkg::XR_VID_VSIZE, V_VISIBLE);
    check_frames(1);                                // blanked, border only

    write_check(xr_regs_pkg::XR_VID_LEFT, 16'h0006, 16'h0006);
    write_check(xr_regs_pkg::XR_VID_RIGHT, 16'h000b, 16'h000b);
    write_check(xr_regs_pkg::XR_PA_GFX_CTRL, 16'ha5ff, 16'ha580);
    write_check(xr_regs_pkg::XR_PA_DISP_ADDR, 16'h1234, 16'h1234);
    write_check(xr_regs_pkg::XR_PA_LINE_LEN, 16'h0009, 16'h0009);
    write_check(xr_regs_pkg::XR_VID_CTRL, 16'hc300, 16'hc300);

    write_reg(xr_regs_pkg::XR_PA_GFX_CTRL, 16'h3c00);
    write_reg(xr_regs_pkg::XR_PA_DISP_ADDR, 16'h0100);
    write_reg(xr_regs_pkg::XR_PA_LINE_LEN, 16'd10);   // stride wider than a line
    write_reg(xr_regs_pkg::XR_VID_LEFT, 16'd0);
    write_reg(xr_regs_pkg::XR_VID_RIGHT, H_VISIBLE);
    check_frames(2);

    write_reg(xr_regs_pkg::XR_VID_LEFT, 16'd3);
    write_reg(xr_regs_pkg::XR_VID_RIGHT, 16'd13);
    write_reg(xr_regs_pkg::XR_VID_CTRL, 16'h5a00);
    check_frames(1);

    repeat (3) begin
        read_reg(xr_regs_pkg::XR_SCANLINE, data);
        if (data >= V_TOTAL) begin
            reg_errors++;
            $display("Error: reg_data_o scan line %h is not below %h", data, V_TOTAL);
        end
        repeat (37) @(posedge clk);
    end

    write_reg(xr_regs_pkg::XR_VID_CTRL, 16'h5a05);
    @(posedge clk);
    if ((intr_o & SW_MASK) !== 4'h5) begin
        intr_errors++;
        $display("Error: intr_o software bits are %h, expected %h", intr_o & SW_MASK, 4'h5);
    end
    @(posedge clk);
    if ((intr_o & SW_MASK) !== 4'h0) begin
        intr_errors++;
        $display("Error: intr_o software bits are %h, expected %h", intr_o & SW_MASK, 4'h0);
    end
    check_frames(2);
    if (sw_intr_count != 1) begin
        intr_errors++;
        $display("The software interrupt bits pulsed %0d times, once was expected", sw_intr_count);
    end

    total = pixel_errors + frame_errors + sync_errors + reg_errors + intr_errors +
            dut_i.checks_i.failures;
    $display("errors: pixel %0d, frame %0d, sync %0d, register %0d, interrupt %0d, assertion %0d",
             pixel_errors, frame_errors, sync_errors, reg_errors, intr_errors,
             dut_i.checks_i.failures);
    if (total == 0) begin
        $display("Simulation finished: PASS");
    end else begin
        $display("Simulation finished: FAIL");
    end
    $finish;
end

endmodule

`default_nettype wire
